// ==== include/alu_regmap.svh ====
//############################################################################
// ALU register map
// Byte offsets of the AXI4-Lite registers and the bit layout of the
// control and result words, shared by the slave and its testbench
//############################################################################

`ifndef ALU_REGMAP_SVH
`define ALU_REGMAP_SVH

// Register byte offsets within the 16-byte window
`define ALU_REG_A      4'h0
`define ALU_REG_B      4'h4
`define ALU_REG_CTRL   4'h8
`define ALU_REG_RESULT 4'hc

// Control word fields
`define ALU_CTRL_OP_MSB  2
`define ALU_CTRL_OP_LSB  0
`define ALU_CTRL_CIN_BIT 4

// Flag positions in the result word
`define ALU_RESULT_CARRY_BIT 16
`define ALU_RESULT_OVR_BIT   17

`endif

// ==== hdl/alu_pkg.sv ====
//############################################################################
// ALU package
// Function select and bus response encodings, plus the control and flag
// bundles that pass between the register slave and the slice cascade
//############################################################################

package alu_pkg;

	// Byte address width of the register block
	localparam int AXIL_ADDR_WIDTH = 4;

	// Bus data width, fixed by the register layout
	localparam int AXIL_DATA_WIDTH = 32;

	// Function select, numbered as on the 382 select pins S2..S0
	typedef enum logic [2:0] {
		op_clear     = 3'd0,
		op_b_minus_a = 3'd1,
		op_a_minus_b = 3'd2,
		op_a_plus_b  = 3'd3,
		op_xor       = 3'd4,
		op_or        = 3'd5,
		op_and       = 3'd6,
		op_preset    = 3'd7
	} alu_op_e;

	// Response codes driven on bresp and rresp
	typedef enum logic [1:0] {
		resp_okay   = 2'b00,
		resp_slverr = 2'b10
	} axil_resp_e;

	// Operation request handed to the cascade
	typedef struct packed {
		alu_op_e op;
		logic    carry_in;
	} alu_ctrl_t;

	// Status returned by the top slice
	typedef struct packed {
		logic carry_out;
		logic overflow;
	} alu_flags_t;

endpackage

// ==== hdl/alu_slice.sv ====
//############################################################################
// ALU slice
// One 4-bit slice with the 382 function set: clear, two subtractions,
// add, xor, or, and and preset, with ripple carry and signed overflow
//############################################################################

`timescale 1ns/100ps

module alu_slice (
	input  logic             [3:0] a,
	input  logic             [3:0] b,
	input  alu_pkg::alu_op_e       op,
	input  logic                   carry_in,
	output logic             [3:0] f,
	output logic                   carry_out,
	output logic                   overflow
);
	import alu_pkg::*;

	// Operands after the inversion that the subtractions need
	logic [3:0] x;
	logic [3:0] y;
	logic [3:0] gen;
	logic [3:0] prop;
	logic [4:0] carry;
	logic       arith;

	// Subtraction is addition with one operand complemented
	always_comb begin
		x = a;
		y = b;
		arith = 1'b1;
		case (op)
			op_b_minus_a: x = ~a;
			op_a_minus_b: y = ~b;
			op_a_plus_b:  arith = 1'b1;
			default:      arith = 1'b0;
		endcase
	end

	// Per-bit generate and propagate, as in the device's internal gating
	assign gen  = x & y;
	assign prop = x ^ y;

	// Carry ripples bit by bit, no lookahead
	always_comb begin
		carry[0] = carry_in;
		for (int i = 0; i < 4; i++) begin
			carry[i+1] = gen[i] | (prop[i] & carry[i]);
		end
	end

	always_comb begin
		case (op)
			op_clear:     f = 4'h0;
			op_b_minus_a: f = prop ^ carry[3:0];
			op_a_minus_b: f = prop ^ carry[3:0];
			op_a_plus_b:  f = prop ^ carry[3:0];
			op_xor:       f = a ^ b;
			op_or:        f = a | b;
			op_and:       f = a & b;
			default:      f = 4'hf;
		endcase
	end

	// Flags only mean something for the three arithmetic functions
	assign carry_out = arith & carry[4];
	// Signed overflow when the carries into and out of the sign bit differ
	assign overflow  = arith & (carry[3] ^ carry[4]);

endmodule

// ==== hdl/alu_cascade.sv ====
//############################################################################
// ALU cascade
// Chains DATA_WIDTH/4 slices through their carry lines like the TTL
// parts on a board and registers the full-width result and flags
//############################################################################

`timescale 1ns/100ps

module alu_cascade #(
	parameter int DATA_WIDTH = 16
) (
	input  logic                      clk,
	input  logic                      reset,
	input  logic     [DATA_WIDTH-1:0] operand_a,
	input  logic     [DATA_WIDTH-1:0] operand_b,
	input  alu_pkg::alu_ctrl_t        ctrl,
	output logic     [DATA_WIDTH-1:0] result,
	output alu_pkg::alu_flags_t       flags
);
	import alu_pkg::*;

	localparam int NUM_SLICES = DATA_WIDTH / 4;

	// carry[i] feeds slice i, carry[NUM_SLICES] leaves the top slice
	logic [NUM_SLICES:0]   carry;
	logic [NUM_SLICES-1:0] slice_ovr;
	logic [DATA_WIDTH-1:0] sum;
	alu_flags_t            flags_next;

	// Width must split evenly into slices and fit the bus word
	if ((DATA_WIDTH % 4 != 0) || (DATA_WIDTH < 4) || (DATA_WIDTH > 32)) begin : g_bad_width
		$error("DATA_WIDTH must be a multiple of 4 between 4 and 32");
	end

	assign carry[0] = ctrl.carry_in;

	for (genvar i = 0; i < NUM_SLICES; i++) begin : g_slice
		alu_slice u_slice (
			.a         (operand_a[4*i +: 4]),
			.b         (operand_b[4*i +: 4]),
			.op        (ctrl.op),
			.carry_in  (carry[i]),
			.f         (sum[4*i +: 4]),
			.carry_out (carry[i+1]),
			.overflow  (slice_ovr[i])
		);
	end

	// Only the most significant slice sees the true sign bit
	assign flags_next = '{carry_out: carry[NUM_SLICES], overflow: slice_ovr[NUM_SLICES-1]};

	// Single register stage after the ripple path
	always_ff @(posedge clk) begin
		if (reset) begin
			result <= '0;
			flags  <= '0;
		end else begin
			result <= sum;
			flags  <= flags_next;
		end
	end

endmodule

// ==== hdl/axil_alu_regs.sv ====
//############################################################################
// AXI4-Lite register slave for the ALU
// Holds operand A, operand B and the control word, returns the registered
// result with carry and overflow, and flags bad offsets with SLVERR
//############################################################################

`timescale 1ns/100ps

`include "alu_regmap.svh"

module axil_alu_regs #(
	parameter int DATA_WIDTH = 16
) (
	input  logic                                   clk,
	input  logic                                   reset,
	// Write address channel
	input  logic                                   awvalid,
	output logic                                   awready,
	input  logic     [alu_pkg::AXIL_ADDR_WIDTH-1:0] awaddr,
	// Write data channel, byte strobes are not used and every write is a full word
	input  logic                                   wvalid,
	output logic                                   wready,
	input  logic     [alu_pkg::AXIL_DATA_WIDTH-1:0] wdata,
	input  logic   [alu_pkg::AXIL_DATA_WIDTH/8-1:0] wstrb,
	// Write response channel
	output logic                                   bvalid,
	input  logic                                   bready,
	output alu_pkg::axil_resp_e                    bresp,
	// Read address channel
	input  logic                                   arvalid,
	output logic                                   arready,
	input  logic     [alu_pkg::AXIL_ADDR_WIDTH-1:0] araddr,
	// Read data channel
	output logic                                   rvalid,
	input  logic                                   rready,
	output logic     [alu_pkg::AXIL_DATA_WIDTH-1:0] rdata,
	output alu_pkg::axil_resp_e                    rresp,
	// Towards the slice cascade
	output logic                  [DATA_WIDTH-1:0] operand_a,
	output logic                  [DATA_WIDTH-1:0] operand_b,
	output alu_pkg::alu_ctrl_t                     ctrl,
	input  logic                  [DATA_WIDTH-1:0] result,
	input  alu_pkg::alu_flags_t                    flags
);
	import alu_pkg::*;

	logic                       wr_fire;
	logic                       rd_fire;
	logic                       wr_okay;
	logic [AXIL_DATA_WIDTH-1:0] rd_word;
	axil_resp_e                 rd_resp;

	// Address and data were both presented and accepted this cycle
	assign wr_fire = awvalid & awready & wvalid & wready;
	assign rd_fire = arvalid & arready;

	// Only the three writable registers accept data
	assign wr_okay = (awaddr == `ALU_REG_A) || (awaddr == `ALU_REG_B) ||
		(awaddr == `ALU_REG_CTRL);

	// Read data is zero-extended, unknown offsets give zero with an error
	always_comb begin
		rd_word = '0;
		rd_resp = resp_okay;
		case (araddr)
			`ALU_REG_A: rd_word[DATA_WIDTH-1:0] = operand_a;
			`ALU_REG_B: rd_word[DATA_WIDTH-1:0] = operand_b;
			`ALU_REG_CTRL: begin
				rd_word[`ALU_CTRL_OP_MSB:`ALU_CTRL_OP_LSB] = ctrl.op;
				rd_word[`ALU_CTRL_CIN_BIT] = ctrl.carry_in;
			end
			`ALU_REG_RESULT: begin
				// Flags sit above a 16-bit result at bits 16 and 17
				rd_word[DATA_WIDTH-1:0] = result;
				rd_word[`ALU_RESULT_CARRY_BIT] = flags.carry_out;
				rd_word[`ALU_RESULT_OVR_BIT] = flags.overflow;
			end
			default: rd_resp = resp_slverr;
		endcase
	end

	// Write side: one-cycle ready pulse, register update, then response
	always_ff @(posedge clk) begin
		if (reset) begin
			awready   <= 1'b0;
			wready    <= 1'b0;
			bvalid    <= 1'b0;
			bresp     <= resp_okay;
			operand_a <= '0;
			operand_b <= '0;
			ctrl      <= '0;
		end else begin
			// A pending response holds off the next write
			if (awvalid && wvalid && !bvalid && !awready && !wready) begin
				awready <= 1'b1;
				wready  <= 1'b1;
			end else begin
				awready <= 1'b0;
				wready  <= 1'b0;
			end

			if (wr_fire) begin
				bvalid <= 1'b1;
				bresp  <= wr_okay ? resp_okay : resp_slverr;
				// Operand bits above DATA_WIDTH are dropped
				case (awaddr)
					`ALU_REG_A: operand_a <= wdata[DATA_WIDTH-1:0];
					`ALU_REG_B: operand_b <= wdata[DATA_WIDTH-1:0];
					`ALU_REG_CTRL: begin
						ctrl.op       <= alu_op_e'(wdata[`ALU_CTRL_OP_MSB:`ALU_CTRL_OP_LSB]);
						ctrl.carry_in <= wdata[`ALU_CTRL_CIN_BIT];
					end
					default: ctrl <= ctrl;
				endcase
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	// Read side: ready pulse, then data held until the master takes it
	always_ff @(posedge clk) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
			rdata   <= '0;
			rresp   <= resp_okay;
		end else begin
			if (arvalid && !rvalid && !arready) begin
				arready <= 1'b1;
			end else begin
				arready <= 1'b0;
			end

			if (rd_fire) begin
				rvalid <= 1'b1;
				rdata  <= rd_word;
				rresp  <= rd_resp;
			end else if (rvalid && rready) begin
				rvalid <= 1'b0;
			end
		end
	end

endmodule

// ==== hdl/alu_top.sv ====
//############################################################################
// Memory-mapped ALU top level
// Joins the AXI4-Lite register slave to the rippled slice cascade
//############################################################################

`timescale 1ns/100ps

module alu_top #(
	parameter int DATA_WIDTH = 16
) (
	input  logic                                     clk,
	input  logic                                     reset,
	input  logic                                     awvalid,
	output logic                                     awready,
	input  logic       [alu_pkg::AXIL_ADDR_WIDTH-1:0] awaddr,
	input  logic                                     wvalid,
	output logic                                     wready,
	input  logic       [alu_pkg::AXIL_DATA_WIDTH-1:0] wdata,
	input  logic     [alu_pkg::AXIL_DATA_WIDTH/8-1:0] wstrb,
	output logic                                     bvalid,
	input  logic                                     bready,
	output alu_pkg::axil_resp_e                      bresp,
	input  logic                                     arvalid,
	output logic                                     arready,
	input  logic       [alu_pkg::AXIL_ADDR_WIDTH-1:0] araddr,
	output logic                                     rvalid,
	input  logic                                     rready,
	output logic       [alu_pkg::AXIL_DATA_WIDTH-1:0] rdata,
	output alu_pkg::axil_resp_e                      rresp
);
	import alu_pkg::*;

	// Register outputs into the cascade and its registered status back
	logic [DATA_WIDTH-1:0] operand_a;
	logic [DATA_WIDTH-1:0] operand_b;
	alu_ctrl_t             ctrl;
	logic [DATA_WIDTH-1:0] result;
	alu_flags_t            flags;

	axil_alu_regs #(
		.DATA_WIDTH (DATA_WIDTH)
	) u_regs (
		.clk       (clk),
		.reset     (reset),
		.awvalid   (awvalid),
		.awready   (awready),
		.awaddr    (awaddr),
		.wvalid    (wvalid),
		.wready    (wready),
		.wdata     (wdata),
		.wstrb     (wstrb),
		.bvalid    (bvalid),
		.bready    (bready),
		.bresp     (bresp),
		.arvalid   (arvalid),
		.arready   (arready),
		.araddr    (araddr),
		.rvalid    (rvalid),
		.rready    (rready),
		.rdata     (rdata),
		.rresp     (rresp),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.ctrl      (ctrl),
		.result    (result),
		.flags     (flags)
	);

	alu_cascade #(
		.DATA_WIDTH (DATA_WIDTH)
	) u_cascade (
		.clk       (clk),
		.reset     (reset),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.ctrl      (ctrl),
		.result    (result),
		.flags     (flags)
	);

endmodule

// ==== verif/alu_top_assertions.sv ====
//############################################################################
// ALU register slave checks
// Handshake and reset rules of the AXI4-Lite slave, bound into every
// instance of it
//############################################################################

`timescale 1ns/100ps

module alu_top_assertions (
	input logic                                clk,
	input logic                                reset,
	input logic                                awready,
	input logic                                wready,
	input logic                                bvalid,
	input logic                                bready,
	input alu_pkg::axil_resp_e                 bresp,
	input logic                                arready,
	input logic                                rvalid,
	input logic                                rready,
	input logic [alu_pkg::AXIL_DATA_WIDTH-1:0] rdata,
	input alu_pkg::axil_resp_e                 rresp
);

	// Count of failed assertions, the testbench polls it
	int failures = 0;

	// A write response stays put until the master takes it
	assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid && $stable(bresp))
	else begin
		$error("bvalid or bresp changed before bready");
		failures++;
	end

	// Same rule on the read data channel
	assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
	else begin
		$error("rvalid, rdata or rresp changed before rready");
		failures++;
	end

	// Address and data of a write are always accepted on the same cycle
	assert property (@(posedge clk) disable iff (reset) awready == wready)
	else begin
		$error("awready and wready differ");
		failures++;
	end

	// A reset clock leaves both response channels idle
	assert property (@(posedge clk) reset |=> !bvalid && !rvalid)
	else begin
		$error("bvalid or rvalid high after a reset clock");
		failures++;
	end

	assert property (@(posedge clk) disable iff (reset)
		!$isunknown({awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp}))
	else begin
		$error("slave output unknown after reset");
		failures++;
	end

endmodule

bind axil_alu_regs alu_top_assertions u_assertions (.*);

// ==== verif/tb_alu_top.sv ====
//############################################################################
// ALU testbench
// Drives the AXI4-Lite ALU through a table of hand-worked vectors, the
// register map rules, back-pressure and random vectors from a model
//############################################################################

`timescale 1ns/100ps

`include "alu_regmap.svh"

module tb_alu_top;
	import alu_pkg::*;

	localparam int DATA_WIDTH = 16;
	localparam int CLK_PERIOD = 40;
	localparam int NUM_VECTORS = 20;
	localparam int NUM_RANDOM = 200;
	// Four bus transfers per vector plus the register map tests
	localparam int NUM_TRANSACTIONS = NUM_VECTORS * 4 + NUM_RANDOM * 4 + 11;

	typedef struct packed {
		logic [DATA_WIDTH-1:0] a;
		logic [DATA_WIDTH-1:0] b;
		alu_op_e               op;
		logic                  cin;
		logic [DATA_WIDTH-1:0] result;
		alu_flags_t            flags;
	} vector_t;

	logic                         clk;
	logic                         reset;
	logic                         awvalid;
	logic                         awready;
	logic [AXIL_ADDR_WIDTH-1:0]   awaddr;
	logic                         wvalid;
	logic                         wready;
	logic [AXIL_DATA_WIDTH-1:0]   wdata;
	logic [AXIL_DATA_WIDTH/8-1:0] wstrb;
	logic                         bvalid;
	logic                         bready;
	axil_resp_e                   bresp;
	logic                         arvalid;
	logic                         arready;
	logic [AXIL_ADDR_WIDTH-1:0]   araddr;
	logic                         rvalid;
	logic                         rready;
	logic [AXIL_DATA_WIDTH-1:0]   rdata;
	axil_resp_e                   rresp;
	integer                       seed;

	// Hand-worked vectors with the flags given as {carry_out, overflow}
	vector_t vectors [NUM_VECTORS] = '{
		'{16'hffff, 16'hffff, op_clear,     1'b1, 16'h0000, 2'b00},
		'{16'h8000, 16'h8000, op_preset,    1'b0, 16'hffff, 2'b00},
		'{16'h0000, 16'h0000, op_a_plus_b,  1'b0, 16'h0000, 2'b00},
		'{16'hffff, 16'h0001, op_a_plus_b,  1'b0, 16'h0000, 2'b10},
		'{16'h7fff, 16'h0001, op_a_plus_b,  1'b0, 16'h8000, 2'b01},
		'{16'h8000, 16'h8000, op_a_plus_b,  1'b0, 16'h0000, 2'b11},
		'{16'hffff, 16'hffff, op_a_plus_b,  1'b1, 16'hffff, 2'b10},
		'{16'h7fff, 16'h0000, op_a_plus_b,  1'b1, 16'h8000, 2'b01},
		'{16'h0005, 16'h0003, op_a_minus_b, 1'b1, 16'h0002, 2'b10},
		'{16'h0003, 16'h0005, op_a_minus_b, 1'b1, 16'hfffe, 2'b00},
		'{16'h8000, 16'h0001, op_a_minus_b, 1'b1, 16'h7fff, 2'b11},
		'{16'h0000, 16'h0000, op_a_minus_b, 1'b0, 16'hffff, 2'b00},
		'{16'h7fff, 16'hffff, op_a_minus_b, 1'b1, 16'h8000, 2'b01},
		'{16'h0001, 16'h0000, op_b_minus_a, 1'b1, 16'hffff, 2'b00},
		'{16'h0001, 16'h8000, op_b_minus_a, 1'b1, 16'h7fff, 2'b11},
		'{16'h1234, 16'h1234, op_b_minus_a, 1'b1, 16'h0000, 2'b10},
		'{16'h0000, 16'h0000, op_b_minus_a, 1'b0, 16'hffff, 2'b00},
		'{16'hffff, 16'h0f0f, op_xor,       1'b1, 16'hf0f0, 2'b00},
		'{16'h7fff, 16'h0001, op_or,        1'b0, 16'h7fff, 2'b00},
		'{16'hffff, 16'h8001, op_and,       1'b1, 16'h8001, 2'b00}
	};

	alu_top #(
		.DATA_WIDTH (DATA_WIDTH)
	) u_alu_top (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("** Error %s: expected 0x%h, got 0x%h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_flags(input string name, input alu_flags_t exp, input alu_flags_t act);
		if (act !== exp) begin
			$display("** Error %s: expected 0x%h, got 0x%h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_resp(input string name, input axil_resp_e exp, input axil_resp_e act);
		if (act !== exp) begin
			$display("** Error %s: expected 0x%h, got 0x%h", name, exp, act);
			abort_run();
		end
	endtask

	// Full-word write that holds bready low for stall cycles once bvalid is up
	task automatic axil_write(input logic [AXIL_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
			input int stall, output axil_resp_e resp);
		axil_resp_e first;
		@(negedge clk);
		awaddr = addr;
		wdata = data;
		wstrb = '1;
		awvalid = 1'b1;
		wvalid = 1'b1;
		@(negedge clk);
		while (!awready) @(negedge clk);
		// The transfer happens on the rising edge in between
		@(negedge clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		while (!bvalid) @(negedge clk);
		first = bresp;
		repeat (stall) begin
			@(negedge clk);
			if (!bvalid) begin
				$display("bvalid dropped while bready was still low");
				abort_run();
			end
			check_resp("bresp", first, bresp);
		end
		bready = 1'b1;
		resp = bresp;
		@(negedge clk);
		bready = 1'b0;
	endtask

	// Single read that holds rready low for stall cycles once rvalid is up
	task automatic axil_read(input logic [AXIL_ADDR_WIDTH-1:0] addr, input int stall,
			output logic [31:0] data, output axil_resp_e resp);
		logic [31:0] first_data;
		axil_resp_e  first_resp;
		@(negedge clk);
		araddr = addr;
		arvalid = 1'b1;
		@(negedge clk);
		while (!arready) @(negedge clk);
		@(negedge clk);
		arvalid = 1'b0;
		while (!rvalid) @(negedge clk);
		first_data = rdata;
		first_resp = rresp;
		repeat (stall) begin
			@(negedge clk);
			if (!rvalid) begin
				$display("rvalid dropped while rready was still low");
				abort_run();
			end
			check_data("rdata", first_data, rdata);
			check_resp("rresp", first_resp, rresp);
		end
		rready = 1'b1;
		data = rdata;
		resp = rresp;
		@(negedge clk);
		rready = 1'b0;
	endtask

	// Reference model where a subtraction adds the complement and only arithmetic sets flags
	function automatic logic [DATA_WIDTH-1:0] alu_model(input logic [DATA_WIDTH-1:0] a,
			input logic [DATA_WIDTH-1:0] b, input alu_op_e op, input logic cin,
			output alu_flags_t flags);
		logic [DATA_WIDTH-1:0] x;
		logic [DATA_WIDTH-1:0] y;
		logic [DATA_WIDTH:0]   sum;
		flags = '0;
		x = a;
		y = b;
		case (op)
			op_clear: return '0;
			op_xor: return a ^ b;
			op_or: return a | b;
			op_and: return a & b;
			op_preset: return '1;
			op_a_minus_b: y = ~b;
			op_b_minus_a: begin
				x = b;
				y = ~a;
			end
			default: ;
		endcase
		sum = {1'b0, x} + {1'b0, y} + cin;
		flags.carry_out = sum[DATA_WIDTH];
		// Same-sign operands giving a result of the other sign
		flags.overflow = (x[DATA_WIDTH-1] == y[DATA_WIDTH-1]) &&
			(sum[DATA_WIDTH-1] != x[DATA_WIDTH-1]);
		return sum[DATA_WIDTH-1:0];
	endfunction

	// Load both operands and the control word, then read the result back
	task automatic run_vector(input vector_t v, input int stall);
		axil_resp_e  resp;
		logic [31:0] word;
		word = '0;
		word[`ALU_CTRL_OP_MSB:`ALU_CTRL_OP_LSB] = v.op;
		word[`ALU_CTRL_CIN_BIT] = v.cin;
		axil_write(`ALU_REG_A, {16'h0000, v.a}, stall, resp);
		check_resp("bresp", resp_okay, resp);
		axil_write(`ALU_REG_B, {16'h0000, v.b}, stall, resp);
		check_resp("bresp", resp_okay, resp);
		axil_write(`ALU_REG_CTRL, word, stall, resp);
		check_resp("bresp", resp_okay, resp);
		axil_read(`ALU_REG_RESULT, stall, word, resp);
		check_resp("rresp", resp_okay, resp);
		check_data("result", {16'h0000, v.result}, word & 32'h0000_ffff);
		check_flags("flags", v.flags, {word[`ALU_RESULT_CARRY_BIT], word[`ALU_RESULT_OVR_BIT]});
		check_data("rdata[31:18]", 32'h0, word >> 18);
	endtask

	// Watchdog sized for twenty clocks per bus transfer
	initial begin
		#(NUM_TRANSACTIONS * 20 * CLK_PERIOD);
		$display("Timeout: the tests did not finish in the expected time");
		abort_run();
	end

	always @(negedge clk) begin
		if (u_alu_top.u_regs.u_assertions.failures != 0) begin
			$display("A bus assertion in the register slave failed");
			abort_run();
		end
	end

	initial begin
		axil_resp_e  resp;
		logic [31:0] word;
		logic [31:0] rnd;
		vector_t     v;
		seed = 8;
		clk = 1'b0;
		reset = 1'b1;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		repeat (5) @(negedge clk);
		reset = 1'b0;

		foreach (vectors[i]) begin
			run_vector(vectors[i], 0);
		end

		// Register readback where operand bits above the width come back as zero
		axil_write(`ALU_REG_A, 32'hdead_beef, 0, resp);
		check_resp("bresp", resp_okay, resp);
		axil_write(`ALU_REG_B, 32'h1234_5678, 0, resp);
		check_resp("bresp", resp_okay, resp);
		axil_write(`ALU_REG_CTRL, 32'hffff_fff5, 0, resp);
		check_resp("bresp", resp_okay, resp);
		axil_read(`ALU_REG_A, 5, word, resp);
		check_resp("rresp", resp_okay, resp);
		check_data("rdata", 32'h0000_beef, word);
		axil_read(`ALU_REG_B, 5, word, resp);
		check_resp("rresp", resp_okay, resp);
		check_data("rdata", 32'h0000_5678, word);
		axil_read(`ALU_REG_CTRL, 5, word, resp);
		check_resp("rresp", resp_okay, resp);
		check_data("rdata", 32'h0000_0015, word);

		// Result of beef or 5678 under stalls on both sides followed by rejected writes
		axil_read(`ALU_REG_RESULT, 5, word, resp);
		check_resp("rresp", resp_okay, resp);
		check_data("rdata", 32'h0000_feff, word);
		axil_write(`ALU_REG_RESULT, 32'h1234_5678, 5, resp);
		check_resp("bresp", resp_slverr, resp);
		axil_write(4'h1, 32'h0000_0000, 0, resp);
		check_resp("bresp", resp_slverr, resp);
		axil_read(`ALU_REG_RESULT, 0, word, resp);
		check_resp("rresp", resp_okay, resp);
		check_data("rdata", 32'h0000_feff, word);
		axil_read(4'h2, 0, word, resp);
		check_resp("rresp", resp_slverr, resp);
		check_data("rdata", 32'h0000_0000, word);

		for (int i = 0; i < NUM_RANDOM; i++) begin
			rnd = $random(seed);
			v.a = rnd[15:0];
			v.b = rnd[31:16];
			rnd = $random(seed);
			v.op = alu_op_e'(rnd[2:0]);
			v.cin = rnd[3];
			v.result = alu_model(v.a, v.b, v.op, v.cin, v.flags);
			run_vector(v, rnd[5:4]);
		end

		if (u_alu_top.u_regs.u_assertions.failures != 0) begin
			$display("A bus assertion in the register slave failed");
			abort_run();
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule

// ==== filelist.f ====
+incdir+include
hdl/alu_pkg.sv
hdl/alu_slice.sv
hdl/alu_cascade.sv
hdl/axil_alu_regs.sv
hdl/alu_top.sv
verif/alu_top_assertions.sv
verif/tb_alu_top.sv
